// File: sim.f
src/qsic_pkg.sv
src/bus_sync.sv
src/slave_cycle.sv
src/config_reg.sv
src/panel_shifter.sv
src/panel_mux.sv
src/qsic_top.sv
test/qsic_assertions.sv
test/tb_qsic.sv

// File: Makefile
# Verilator build and run for the qbus slave testbench

VERILATOR ?= verilator
TOP       ?= tb_qsic
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(wildcard src/*.sv test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) $(VFLAGS)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_qsic.sv
/*
 * directed testbench for the qbus slave and the panel scan
 * bus master drives strobes on the rising edge, outputs are sampled on the falling edge
 * panel clock divider is 1, so one frame takes about 300 cycles
 */

`timescale 1ns/10ps

module tb_qsic import qsic_pkg::*; ();

   localparam logic [dal_width-1:0] reg_addr   = 22'o17777720;  // config reg in the i/o page
   localparam logic [dal_width-1:0] other_addr = 22'o17777722;  // neighbour, not decoded
   localparam logic [15:0] reset_word = 16'h220A;   // list 2,1,0,1 count 2
   localparam logic [15:0] keep_mask  = ~16'hC924;  // gaps 15,14,11,8,5,2 read as zero
   localparam logic [15:0] dark_word  = 16'h0492;   // every entry 2, count 0
   localparam int addr_hold   = 4;     // master cycles around sync
   localparam int reply_limit = 20;
   localparam int frame_limit = 1000;

   logic                 clk20, rst, rsync, rdin, rdout, rinit, bs7, wtbt;
   logic [dal_width-1:0] dal_in, dal_out;
   logic                 dal_tx, dal_be, dal_st, trply;
   logic                 ip_clk_pin, ip_out_pin, ip_latch_pin;
   integer               seed;
   logic [15:0]          wdata;
   logic [frame_bits-1:0] got;
   int                   edges;
   int                   k;

   qsic_top #(.settle_cycles(1), .panel_clk_div(1)) u_dut (
      .clk20(clk20), .rst(rst), .rsync(rsync), .rdin(rdin), .rdout(rdout),
      .rinit(rinit), .bs7(bs7), .wtbt(wtbt), .dal_in(dal_in), .dal_out(dal_out),
      .dal_tx(dal_tx), .dal_be(dal_be), .dal_st(dal_st), .trply(trply),
      .ip_clk_pin(ip_clk_pin), .ip_out_pin(ip_out_pin), .ip_latch_pin(ip_latch_pin)
   );

   initial clk20 = 1'b0;
   always #10 clk20 = ~clk20;   // 50 MHz

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string test, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
         else fail_run($sformatf("FAIL %s: expected 'h%0h, actual 'h%0h", test, exp, act));
   endtask

   task automatic check_frame(input string test, input logic [frame_bits-1:0] exp,
                              input logic [frame_bits-1:0] act);
      assert (act === exp)
         else fail_run($sformatf("FAIL %s: expected 'h%0h, actual 'h%0h", test, exp, act));
   endtask

   task automatic wait_trply(input string test, input logic level);
      int n;
      n = 0;
      @(negedge clk20);
      while (trply !== level) begin
         if (n == reply_limit)
            fail_run($sformatf("%s: trply never went to %0b", test, level));
         n++;
         @(negedge clk20);
      end
   endtask

   task automatic wait_latch(input string test, input logic level);
      int n;
      n = 0;
      @(negedge clk20);
      while (ip_latch_pin !== level) begin
         if (n == frame_limit)
            fail_run($sformatf("%s: latch pin stuck, never went to %0b", test, level));
         n++;
         @(negedge clk20);
      end
   endtask

   // address phase, held until the capture is done
   task automatic start_cycle(input logic [dal_width-1:0] addr, input logic bs7_v,
                              input logic write);
      @(posedge clk20);
      dal_in <= addr;
      bs7    <= bs7_v;
      wtbt   <= write;   // high means dato
      rsync  <= 1'b1;
      repeat (addr_hold) @(posedge clk20);   // 2 sync stages + capture
      bs7    <= 1'b0;
      wtbt   <= 1'b0;
      dal_in <= '0;
   endtask

   task automatic end_cycle();
      @(posedge clk20);
      rsync <= 1'b0;
      repeat (addr_hold) @(posedge clk20);  // s_sync low before next cycle
   endtask

   task automatic dati(input string test, input logic [dal_width-1:0] addr, input logic bs7_v,
                       input logic reply, input logic [15:0] exp_word);
      int n;
      start_cycle(addr, bs7_v, 1'b0);
      @(posedge clk20);
      rdin <= 1'b1;
      if (reply) begin
         wait_trply(test, 1'b1);
         check_word({test, " data"}, 32'(exp_word), 32'(dal_out[15:0]));
         check_word({test, " upper lines"}, 32'd0, 32'(dal_out[dal_width-1:16]));
         check_word({test, " tx/be/st"}, 32'b111, 32'({dal_tx, dal_be, dal_st}));
         @(posedge clk20);
         rdin <= 1'b0;
         wait_trply(test, 1'b0);
         check_word({test, " release"}, 32'd0, 32'({dal_tx, dal_be, dal_st}));
      end else begin
         for (n = 0; n < reply_limit; n++) begin   // slave must stay quiet
            @(negedge clk20);
            check_word({test, " trply"}, 32'd0, 32'(trply));
            check_word({test, " dal_tx"}, 32'd0, 32'(dal_tx));
         end
         @(posedge clk20);
         rdin <= 1'b0;
      end
      end_cycle();
   endtask

   task automatic dato(input string test, input logic [15:0] word);
      start_cycle(reg_addr, 1'b1, 1'b1);
      @(posedge clk20);
      dal_in <= {{(dal_width - 16){1'b0}}, word};
      @(posedge clk20);
      rdout <= 1'b1;   // data already stable on dal
      wait_trply(test, 1'b1);
      @(posedge clk20);
      rdout <= 1'b0;
      wait_trply(test, 1'b0);
      end_cycle();
   endtask

   // one frame between two latch pulses, bits taken at falling pin clock
   task automatic capture_frame(input string test, output logic [frame_bits-1:0] bits,
                                output int nedges);
      int   n;
      logic prev_clk;
      wait_latch(test, 1'b0);
      wait_latch(test, 1'b1);
      bits     = '0;
      nedges   = 0;
      n        = 0;
      prev_clk = 1'b1;
      @(negedge clk20);
      while (ip_latch_pin !== 1'b0) begin
         if (prev_clk && !ip_clk_pin) begin
            bits = {bits[frame_bits-2:0], ~ip_out_pin};   // pins inverted
            nedges++;
         end
         prev_clk = ip_clk_pin;
         if (n == frame_limit) fail_run({test, ": no latch pulse after the frame"});
         n++;
         @(negedge clk20);
      end
   endtask

   initial begin
      seed   = 4;
      rst    = 1'b1;
      rsync  = 1'b0;
      rdin   = 1'b0;
      rdout  = 1'b0;
      rinit  = 1'b0;
      bs7    = 1'b0;
      wtbt   = 1'b0;
      dal_in = '0;
      repeat (4) @(posedge clk20);
      rst <= 1'b0;
      repeat (2) @(posedge clk20);

      dati("default_read", reg_addr, 1'b1, 1'b1, reset_word);
      dati("wrong_addr", other_addr, 1'b1, 1'b0, 16'h0);
      dati("no_bs7", reg_addr, 1'b0, 1'b0, 16'h0);

      wdata = 16'($random(seed));
      dato("random_write", wdata);
      dati("random_read", reg_addr, 1'b1, 1'b1, wdata & keep_mask);

      @(posedge clk20);
      rinit <= 1'b1;
      @(posedge clk20);
      rinit <= 1'b0;
      dati("rinit_read", reg_addr, 1'b1, 1'b1, reset_word);

      dato("lamptest_write", 16'h0000);   // all entries lamptest, count 0
      for (k = 0; k < 2; k++) begin
         capture_frame("lamptest_frame", got, edges);
         check_word("lamptest_edges", 32'(frame_bits), 32'(edges));
         check_frame("lamptest_frame", {frame_bits{1'b1}}, got);
      end

      dato("dark_write", dark_word);
      capture_frame("dark_frame", got, edges);
      check_word("dark_edges", 32'(frame_bits), 32'(edges));
      check_frame("dark_frame", {frame_bits{1'b0}}, got);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: test/qsic_assertions.sv
/*
 * concurrent checks on the reply and transceiver outputs of slave_cycle
 * bound into every slave_cycle instance, idle while rst is high
 */

`timescale 1ns/10ps

module qsic_assertions (
   input logic clk20,
   input logic rst,
   input logic trply,
   input logic dal_tx,
   input logic dal_be,
   input logic dal_st,
   input logic read_cycle,
   input logic match
);

   // dati reply only with the transceivers turned to the bus
   a_read_tx: assert property (@(posedge clk20) disable iff (rst)
      (trply && read_cycle) |-> dal_tx)
      else $error("trply on a read without dal_tx");

   a_be_tx: assert property (@(posedge clk20) disable iff (rst) dal_be |-> dal_tx)
      else $error("dal_be without dal_tx");

   a_st_reply: assert property (@(posedge clk20) disable iff (rst) dal_st |-> trply)
      else $error("dal_st without trply");

   // match is judged the cycle before trply comes up
   a_reply_match: assert property (@(posedge clk20) disable iff (rst)
      $rose(trply) |-> $past(match))
      else $error("trply rose without an address match");

endmodule

bind slave_cycle qsic_assertions u_chk (
   .clk20(clk20), .rst(rst), .trply(trply), .dal_tx(dal_tx), .dal_be(dal_be),
   .dal_st(dal_st), .read_cycle(read_cycle), .match(match)
);

// File: src/qsic_top.sv
/*
 * qbus slave with the panel config register and the indicator panel scan
 * dal lines are split into in, out and tx enable, tristating is left to the pads
 */

`timescale 1ns/10ps

module qsic_top import qsic_pkg::*; #(
   parameter int settle_cycles = 1,
   parameter int panel_clk_div = 4
) (
   input  logic                 clk20,
   input  logic                 rst,
   input  logic                 rsync,
   input  logic                 rdin,
   input  logic                 rdout,
   input  logic                 rinit,
   input  logic                 bs7,
   input  logic                 wtbt,
   input  logic [dal_width-1:0] dal_in,
   output logic [dal_width-1:0] dal_out,
   output logic                 dal_tx,
   output logic                 dal_be,
   output logic                 dal_st,
   output logic                 trply,
   output logic                 ip_clk_pin,
   output logic                 ip_out_pin,
   output logic                 ip_latch_pin
);

   logic                  s_sync, s_din, s_dout;
   logic                  sync_rise, din_rise, dout_rise;
   logic                  wr_en;
   logic [data_width-1:0] wr_data, rd_data;
   config_word_u          cfg;
   logic [dal_width-1:0]  cap_addr;
   logic                  cap_bs7, read_cycle;
   logic                  frame_start, frame_done;
   logic [frame_bits-1:0] frame;

   bus_sync u_sync (
      .clk20(clk20), .rst(rst), .rsync(rsync), .rdin(rdin), .rdout(rdout),
      .s_sync(s_sync), .s_din(s_din), .s_dout(s_dout),
      .sync_rise(sync_rise), .din_rise(din_rise), .dout_rise(dout_rise)
   );

   slave_cycle #(.settle_cycles(settle_cycles)) u_slave (
      .clk20(clk20), .rst(rst), .rinit(rinit),
      .s_sync(s_sync), .s_din(s_din), .s_dout(s_dout),
      .sync_rise(sync_rise), .din_rise(din_rise), .dout_rise(dout_rise),
      .bs7(bs7), .wtbt(wtbt), .dal_in(dal_in), .rd_data(rd_data),
      .wr_en(wr_en), .wr_data(wr_data), .dal_out(dal_out),
      .dal_tx(dal_tx), .dal_be(dal_be), .dal_st(dal_st), .trply(trply),
      .cap_addr(cap_addr), .cap_bs7(cap_bs7), .read_cycle(read_cycle)
   );

   config_reg u_cfg (
      .clk20(clk20), .rst(rst), .rinit(rinit), .wr_en(wr_en),
      .wr_data(wr_data), .rd_data(rd_data), .cfg(cfg)
   );

   // monitor shows the synchronized strobes
   panel_mux u_mux (
      .clk20(clk20), .rst(rst), .rinit(rinit), .frame_done(frame_done),
      .cfg(cfg), .cap_addr(cap_addr), .cap_bs7(cap_bs7), .read_cycle(read_cycle),
      .rsync(s_sync), .rdin(s_din), .rdout(s_dout), .trply(trply), .dal_tx(dal_tx),
      .frame_start(frame_start), .frame(frame)
   );

   panel_shifter #(.panel_clk_div(panel_clk_div)) u_shift (
      .clk20(clk20), .rst(rst), .frame_start(frame_start), .frame(frame),
      .ip_clk_pin(ip_clk_pin), .ip_out_pin(ip_out_pin), .ip_latch_pin(ip_latch_pin),
      .frame_done(frame_done)
   );

endmodule

// File: src/panel_mux.sv
/*
 * walks the configured panel list and hands one frame at a time to the shifter
 * steps 0 up to cfg count are shown, then back to 0
 * frame is sampled by the shifter in the frame_start cycle
 */

`timescale 1ns/10ps

module panel_mux import qsic_pkg::*; (
   input  logic                  clk20,
   input  logic                  rst,
   input  logic                  rinit,
   input  logic                  frame_done,
   input  config_word_u          cfg,
   input  logic [dal_width-1:0]  cap_addr,
   input  logic                  cap_bs7,
   input  logic                  read_cycle,
   input  logic                  rsync,
   input  logic                  rdin,
   input  logic                  rdout,
   input  logic                  trply,
   input  logic                  dal_tx,
   output logic                  frame_start,
   output logic [frame_bits-1:0] frame
);

   logic [1:0]                 step;
   logic                       kick;   // first frame after reset
   panel_sel_t                 sel;
   logic [panel_word_bits-1:0] mon_w0, mon_w1, mon_w2, mon_w3;

   always_ff @(posedge clk20) begin
      if (rst) begin
         step        <= '0;
         kick        <= 1'b1;
         frame_start <= 1'b0;
      end else begin
         kick        <= 1'b0;
         frame_start <= kick || frame_done;
         if (rinit) step <= '0;   // shifter keeps running, list restarts
         else if (frame_start) step <= (step == cfg.fields.count) ? 2'd0 : step + 2'd1;
      end
   end

   // list entry for this step
   always_comb begin
      case (step)
         2'd0:    sel = cfg.fields.list0;
         2'd1:    sel = cfg.fields.list1;
         2'd2:    sel = cfg.fields.list2;
         default: sel = cfg.fields.list3;
      endcase
   end

   // bus monitor, lamp positions kept from the full qsic panel
   assign mon_w0 = {dal_tx, 35'b0};
   assign mon_w1 = {read_cycle, cap_bs7, cap_addr, 12'b0};
   assign mon_w2 = {2'b0, rsync, rdin, rdout, 31'b0};   // live strobes
   assign mon_w3 = {5'b0, trply, 30'b0};                 // what we drive

   always_comb begin
      case (sel)
         sel_lamptest: frame = '1;
         sel_monitor:  frame = {mon_w0, mon_w1, mon_w2, mon_w3};
         default:      frame = '0;   // slots 2 and 3 dark
      endcase
   end

endmodule

// File: src/panel_shifter.sv
/*
 * shifts one 144 bit frame to the indicator panels, msb first
 * each bit is set up during the low half of the panel clock
 * frame_start is ignored while a frame is still going out
 * pins are inverted on the board, idle level is high
 */

`timescale 1ns/10ps

module panel_shifter import qsic_pkg::*; #(
   parameter int panel_clk_div = 4  // clk20 cycles per half panel clock
) (
   input  logic                  clk20,
   input  logic                  rst,
   input  logic                  frame_start,
   input  logic [frame_bits-1:0] frame,
   output logic                  ip_clk_pin,
   output logic                  ip_out_pin,
   output logic                  ip_latch_pin,
   output logic                  frame_done
);

   localparam int div_w = (panel_clk_div > 1) ? $clog2(panel_clk_div) : 1;
   localparam int bit_w = $clog2(frame_bits);

   localparam logic [1:0] sh_idle  = 2'd0;
   localparam logic [1:0] sh_shift = 2'd1;
   localparam logic [1:0] sh_latch = 2'd2;

   logic [1:0]            state;
   logic [div_w-1:0]      div_cnt;
   logic                  half;     // 0 low half, 1 high half
   logic [bit_w-1:0]      bit_cnt;
   logic [frame_bits-1:0] sreg;
   logic                  tick;

   assign tick = (div_cnt == div_w'(panel_clk_div - 1));

   always_ff @(posedge clk20) begin
      if (rst) begin
         state      <= sh_idle;
         div_cnt    <= '0;
         half       <= 1'b0;
         bit_cnt    <= '0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         div_cnt    <= (state == sh_idle || tick) ? '0 : div_cnt + 1'b1;
         case (state)
            sh_idle: begin
               half    <= 1'b0;
               bit_cnt <= '0;
               if (frame_start) state <= sh_shift;
            end
            sh_shift: begin
               if (tick) begin
                  half <= ~half;
                  if (half) begin   // end of high half, bit consumed
                     if (bit_cnt == bit_w'(frame_bits - 1)) state <= sh_latch;
                     else bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: begin          // latch held for one full panel clock
               if (tick) begin
                  half <= ~half;
                  if (half) begin
                     state      <= sh_idle;
                     frame_done <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // frame data, no reset needed
   always_ff @(posedge clk20) begin
      if (state == sh_idle && frame_start) sreg <= frame;
      else if (state == sh_shift && tick && half) sreg <= sreg << 1;
   end

   // logical levels inverted onto the pins
   assign ip_clk_pin   = ~((state == sh_shift) && half);
   assign ip_out_pin   = ~((state == sh_shift) && sreg[frame_bits-1]);
   assign ip_latch_pin = ~(state == sh_latch);

endmodule

// File: src/config_reg.sv
/*
 * panel configuration register, list of four panel sources plus a count
 * rinit from the bus restores the default list like rst does
 * gap bits are not stored and read back zero
 */

`timescale 1ns/10ps

module config_reg import qsic_pkg::*; (
   input  logic                  clk20,
   input  logic                  rst,
   input  logic                  rinit,
   input  logic                  wr_en,
   input  logic [data_width-1:0] wr_data,
   output logic [data_width-1:0] rd_data,
   output config_word_u          cfg
);

   config_word_u rd_view;

   always_ff @(posedge clk20) begin
      if (rst || rinit) begin
         cfg <= config_default;
      end else if (wr_en) begin
         // only the list and count fields take the write
         cfg.fields.list0 <= panel_sel_t'(wr_data[1:0]);
         cfg.fields.list1 <= panel_sel_t'(wr_data[4:3]);
         cfg.fields.list2 <= panel_sel_t'(wr_data[7:6]);
         cfg.fields.list3 <= panel_sel_t'(wr_data[10:9]);
         cfg.fields.count <= wr_data[13:12];
      end
   end

   // rebuild the word from fields, gaps forced low
   always_comb begin
      rd_view              = '0;
      rd_view.fields.list0 = cfg.fields.list0;
      rd_view.fields.list1 = cfg.fields.list1;
      rd_view.fields.list2 = cfg.fields.list2;
      rd_view.fields.list3 = cfg.fields.list3;
      rd_view.fields.count = cfg.fields.count;
   end

   assign rd_data = rd_view.raw;

endmodule

// File: src/slave_cycle.sv
/*
 * qbus slave sequencing for one register, bus strobes must be synchronized
 * address is taken from dal_in on sync_rise, so it must still be held then
 * settle_cycles must be at least 1
 */

`timescale 1ns/10ps

module slave_cycle import qsic_pkg::*; #(
   parameter int settle_cycles = 1
) (
   input  logic                  clk20,
   input  logic                  rst,
   input  logic                  rinit,
   input  logic                  s_sync,
   input  logic                  s_din,
   input  logic                  s_dout,
   input  logic                  sync_rise,
   input  logic                  din_rise,
   input  logic                  dout_rise,
   input  logic                  bs7,
   input  logic                  wtbt,
   input  logic [dal_width-1:0]  dal_in,
   input  logic [data_width-1:0] rd_data,
   output logic                  wr_en,
   output logic [data_width-1:0] wr_data,
   output logic [dal_width-1:0]  dal_out,
   output logic                  dal_tx,
   output logic                  dal_be,
   output logic                  dal_st,
   output logic                  trply,
   output logic [dal_width-1:0]  cap_addr,
   output logic                  cap_bs7,
   output logic                  read_cycle
);

   localparam int cnt_w = (settle_cycles > 1) ? $clog2(settle_cycles) : 1;

   // reply states
   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_turn = 2'd1;  // transceivers toward bus, waiting to settle
   localparam logic [1:0] st_rd   = 2'd2;  // dati reply up
   localparam logic [1:0] st_wr   = 2'd3;  // dato reply up

   logic [1:0]       state;
   logic [cnt_w-1:0] settle_cnt;
   logic             match;

   // addressing info grabbed at the start of the cycle
   always_ff @(posedge clk20) begin
      if (rst) begin
         cap_addr   <= '0;
         cap_bs7    <= 1'b0;
         read_cycle <= 1'b0;
      end else if (sync_rise) begin
         cap_addr   <= dal_in;
         cap_bs7    <= bs7;
         read_cycle <= ~wtbt;  // wtbt low during address means dati
      end
   end

   // only inside sync, and only in the i/o page
   assign match = s_sync && cap_bs7 && (cap_addr[reg_addr_width-1:0] == conf_addr);

   always_ff @(posedge clk20) begin
      if (rst || rinit) begin
         state      <= st_idle;
         settle_cnt <= '0;
         dal_tx     <= 1'b0;
         dal_be     <= 1'b0;
         dal_st     <= 1'b0;
         trply      <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               settle_cnt <= '0;
               if (match && din_rise) begin
                  dal_tx <= 1'b1;           // turn the transceivers first
                  state  <= st_turn;
               end else if (match && dout_rise) begin
                  trply <= 1'b1;            // writes answer at once
                  state <= st_wr;
               end
            end
            st_turn: begin
               if (!s_din) begin            // master gave up
                  dal_tx <= 1'b0;
                  state  <= st_idle;
               end else if (settle_cnt == cnt_w'(settle_cycles - 1)) begin
                  trply  <= 1'b1;
                  dal_be <= 1'b1;
                  dal_st <= 1'b1;
                  state  <= st_rd;
               end else begin
                  settle_cnt <= settle_cnt + 1'b1;
               end
            end
            st_rd: begin
               if (!s_din) begin
                  // drop everything together
                  dal_tx <= 1'b0;
                  dal_be <= 1'b0;
                  dal_st <= 1'b0;
                  trply  <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: begin                  // st_wr
               if (!s_dout) begin
                  trply <= 1'b0;
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   // register loads on the dout edge, data already on the lines
   assign wr_en   = match && dout_rise;
   assign wr_data = dal_in[data_width-1:0];

   // upper lines stay zero for a 16 bit register
   assign dal_out = dal_tx ? {{(dal_width - data_width){1'b0}}, rd_data} : '0;

endmodule

// File: src/bus_sync.sv
/*
 * brings rsync, rdin and rdout into the clk20 domain
 * two flops per strobe, a third one for rising edge detect
 * level is valid two cycles after the bus edge
 */

`timescale 1ns/10ps

module bus_sync (
   input  logic clk20,
   input  logic rst,
   input  logic rsync,
   input  logic rdin,
   input  logic rdout,
   output logic s_sync,
   output logic s_din,
   output logic s_dout,
   output logic sync_rise,
   output logic din_rise,
   output logic dout_rise
);

   // bit 2 sync, bit 1 din, bit 0 dout
   logic [2:0] meta;   // first stage, may go metastable
   logic [2:0] lvl;    // stable level
   logic [2:0] prev;   // level one cycle back

   always_ff @(posedge clk20) begin
      if (rst) begin
         meta <= '0;
         lvl  <= '0;
         prev <= '0;
      end else begin
         meta <= {rsync, rdin, rdout};
         lvl  <= meta;
         prev <= lvl;
      end
   end

   assign {s_sync, s_din, s_dout} = lvl;

   // one cycle pulse on each low to high
   assign {sync_rise, din_rise, dout_rise} = lvl & ~prev;

endmodule

// File: src/qsic_pkg.sv
/*
 * shared widths, register address and panel geometry for the qbus slave
 * only the config register at 17720 (octal) in the i/o page is decoded
 * panel frame is 4 words of 36 bits, shifted msb first
 */

package qsic_pkg;

   // bus geometry
   parameter int dal_width      = 22;  // bdal lines
   parameter int data_width     = 16;  // register word
   parameter int reg_addr_width = 13;  // low bits decoded inside the i/o page

   parameter logic [reg_addr_width-1:0] conf_addr = 13'o17720;

   // indicator panel geometry
   parameter int panel_words     = 4;
   parameter int panel_word_bits = 36;
   parameter int frame_bits      = panel_words * panel_word_bits;  // 144

   // panel source index, 2 and 3 show a dark panel
   typedef logic [1:0] panel_sel_t;

   parameter panel_sel_t sel_lamptest = 2'd0;
   parameter panel_sel_t sel_monitor  = 2'd1;

   // field layout of the config word, gaps read back as zero
   typedef struct packed {
      logic [1:0] gap_hi;  // 15:14
      logic [1:0] count;   // 13:12, last list step shown
      logic       gap11;
      panel_sel_t list3;   // 10:9
      logic       gap8;
      panel_sel_t list2;   // 7:6
      logic       gap5;
      panel_sel_t list1;   // 4:3
      logic       gap2;
      panel_sel_t list0;   // 1:0
   } config_fields_t;

   // same 16 bits, raw bus word or decoded list
   typedef union packed {
      logic [data_width-1:0] raw;
      config_fields_t        fields;
   } config_word_u;

   // list 2,1,0,1 and count 2
   parameter config_word_u config_default = 16'h220A;

endpackage
